/* verilog/sched_pkg.sv */
`default_nettype none

package sched_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int PC_W       = 32;

    typedef enum logic [1:0] {
        U_ALU,
        U_LOAD,
        U_STORE,
        U_CTRL
    } unit_e;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SLT, OP_LUI,
        OP_LW, OP_SW,
        OP_BEQ, OP_BNE, OP_JAL, OP_JALR
    } op_e;

    // decoded instruction as it leaves the decode queue
    typedef struct packed {
        logic                  valid;
        unit_e                 unit;
        op_e                   op;
        logic                  use_imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [PC_W-1:0]       pc;
    } instr_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_NO_TMP,
        ST_HAS_TMP
    } issue_state_e;

    // register usage by instruction class
    function automatic logic writes_rd(instr_t ins);
        return (ins.unit == U_ALU) || (ins.unit == U_LOAD) ||
               ((ins.unit == U_CTRL) && (ins.op inside {OP_JAL, OP_JALR}));
    endfunction

    function automatic logic reads_rs1(instr_t ins);
        return !(ins.op inside {OP_LUI, OP_JAL});
    endfunction

    function automatic logic reads_rs2(instr_t ins);
        return ((ins.unit == U_ALU) && !ins.use_imm) || (ins.unit == U_STORE) ||
               ((ins.unit == U_CTRL) && (ins.op inside {OP_BEQ, OP_BNE}));
    endfunction

endpackage

`default_nettype wire

/* verilog/issue_ctrl_if.sv */
`default_nettype none

interface issue_ctrl_if;

    // capture the second queue head into the buffer
    logic tmp_load;
    // candidates come from (buffer, head) instead of (head, next)
    logic use_tmp;
    logic slot0_en;
    logic slot1_en;

    modport fsm (
        output tmp_load, use_tmp, slot0_en, slot1_en
    );

    modport regs (
        input  tmp_load, use_tmp, slot0_en, slot1_en
    );

endinterface

`default_nettype wire

/* verilog/pair_hazard_check.sv */
`default_nettype none

module pair_hazard_check
    import sched_pkg::*;
(
    input  instr_t i_cand0,
    input  instr_t i_cand1,
    output logic   o_hold
);

    logic both_valid;
    logic mem0;
    logic mem1;
    logic both_mem;
    logic both_ctrl;
    logic structural;

    logic wr0;
    logic raw_rs1;
    logic raw_rs2;
    logic data_dep;

    assign both_valid = i_cand0.valid && i_cand1.valid;

    // one memory port and one branch unit
    assign mem0      = (i_cand0.unit == U_LOAD) || (i_cand0.unit == U_STORE);
    assign mem1      = (i_cand1.unit == U_LOAD) || (i_cand1.unit == U_STORE);
    assign both_mem  = mem0 && mem1;
    assign both_ctrl = (i_cand0.unit == U_CTRL) && (i_cand1.unit == U_CTRL);

    assign structural = both_mem || both_ctrl;

    // second instruction reading what the first one writes
    assign wr0 = writes_rd(i_cand0);

    assign raw_rs1 = wr0 && reads_rs1(i_cand1) && (i_cand0.rd == i_cand1.rs1);
    assign raw_rs2 = wr0 && reads_rs2(i_cand1) && (i_cand0.rd == i_cand1.rs2);

    assign data_dep = raw_rs1 || raw_rs2;

    assign o_hold = both_valid && (structural || data_dep);

endmodule

`default_nettype wire

/* verilog/load_use_check.sv */
`default_nettype none

module load_use_check
    import sched_pkg::*;
#(
    parameter bit STALL_ON_LOAD = 1'b1
) (
    input  instr_t i_cand0,
    input  instr_t i_cand1,
    input  instr_t i_slot0,
    input  instr_t i_slot1,
    input  logic   i_hold,
    output logic   o_stall
);

    // nonzero source of a valid candidate matching a load destination
    function automatic logic uses_reg(instr_t cand, instr_t ld);
        logic hit1;
        logic hit2;
        hit1 = reads_rs1(cand) && (cand.rs1 != '0) && (cand.rs1 == ld.rd);
        hit2 = reads_rs2(cand) && (cand.rs2 != '0) && (cand.rs2 == ld.rd);
        return cand.valid && ld.valid && (ld.unit == U_LOAD) && (hit1 || hit2);
    endfunction

    logic hit_cand0;
    logic hit_cand1;

    assign hit_cand0 = uses_reg(i_cand0, i_slot0) || uses_reg(i_cand0, i_slot1);
    assign hit_cand1 = uses_reg(i_cand1, i_slot0) || uses_reg(i_cand1, i_slot1);

    // a held cand1 waits anyway
    assign o_stall = STALL_ON_LOAD && (hit_cand0 || (hit_cand1 && !i_hold));

endmodule

`default_nettype wire

/* verilog/issue_fsm.sv */
`default_nettype none

module issue_fsm
    import sched_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_ready,
    input  logic              i_hold,
    input  logic              i_stall,
    output logic              o_request,
    issue_ctrl_if.fsm         ctrl
);

    issue_state_e state_q;
    issue_state_e state_d;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d       = state_q;
        o_request     = 1'b0;
        ctrl.tmp_load = 1'b0;
        ctrl.use_tmp  = 1'b0;
        ctrl.slot0_en = 1'b0;
        ctrl.slot1_en = 1'b0;

        unique case (state_q)
            ST_IDLE, ST_NO_TMP: begin
                // idle never sees a stall, the slots are still empty
                if (i_ready && !(i_stall && (state_q == ST_NO_TMP))) begin
                    o_request     = 1'b1;
                    ctrl.slot0_en = 1'b1;
                    if (i_hold) begin
                        ctrl.tmp_load = 1'b1;
                        state_d       = ST_HAS_TMP;
                    end else begin
                        ctrl.slot1_en = 1'b1;
                        state_d       = ST_NO_TMP;
                    end
                end
            end
            ST_HAS_TMP: begin
                ctrl.use_tmp = 1'b1;
                if (!i_stall) begin
                    ctrl.slot0_en = 1'b1;
                    if (i_ready && !i_hold) begin
                        // buffer pairs with head, next head refills it
                        ctrl.slot1_en = 1'b1;
                        ctrl.tmp_load = 1'b1;
                        o_request     = 1'b1;
                    end else begin
                        state_d = ST_NO_TMP;
                    end
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/issue_regs.sv */
`default_nettype none

module issue_regs
    import sched_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  instr_t    i_dec0,
    input  instr_t    i_dec1,
    issue_ctrl_if.regs ctrl,
    output instr_t    o_cand0,
    output instr_t    o_cand1,
    output instr_t    o_slot0,
    output instr_t    o_slot1
);

    instr_t tmp_q;
    instr_t slot0_d;
    instr_t slot1_d;

    // older instruction always lands in cand0
    assign o_cand0 = ctrl.use_tmp ? tmp_q  : i_dec0;
    assign o_cand1 = ctrl.use_tmp ? i_dec0 : i_dec1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tmp_q <= '0;
        end else if (ctrl.tmp_load) begin
            tmp_q <= i_dec1;
        end
    end

    always_comb begin
        slot0_d       = o_cand0;
        slot0_d.valid = o_cand0.valid && ctrl.slot0_en;
        slot1_d       = o_cand1;
        slot1_d.valid = o_cand1.valid && ctrl.slot1_en;
    end

    // slots refresh every cycle, nothing waits downstream
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_slot0 <= '0;
            o_slot1 <= '0;
        end else begin
            o_slot0 <= slot0_d;
            o_slot1 <= slot1_d;
        end
    end

endmodule

`default_nettype wire

/* verilog/dual_issue_sched.sv */
`default_nettype none

module dual_issue_sched
    import sched_pkg::*;
#(
    parameter bit STALL_ON_LOAD = 1'b1
) (
    input  logic   clk,
    input  logic   rstn,
    input  logic   i_ready,
    input  instr_t i_dec0,
    input  instr_t i_dec1,
    output logic   o_request,
    output instr_t o_iss0,
    output instr_t o_iss1
);

    instr_t cand0;
    instr_t cand1;
    logic   hold;
    logic   stall;

    issue_ctrl_if u_ctrl_if ();

    issue_regs u_issue_regs (
        .clk     (clk),
        .rstn    (rstn),
        .i_dec0  (i_dec0),
        .i_dec1  (i_dec1),
        .ctrl    (u_ctrl_if.regs),
        .o_cand0 (cand0),
        .o_cand1 (cand1),
        .o_slot0 (o_iss0),
        .o_slot1 (o_iss1)
    );

    pair_hazard_check u_pair_hazard_check (
        .i_cand0 (cand0),
        .i_cand1 (cand1),
        .o_hold  (hold)
    );

    // slots hold what issued last cycle
    load_use_check #(
        .STALL_ON_LOAD (STALL_ON_LOAD)
    ) u_load_use_check (
        .i_cand0 (cand0),
        .i_cand1 (cand1),
        .i_slot0 (o_iss0),
        .i_slot1 (o_iss1),
        .i_hold  (hold),
        .o_stall (stall)
    );

    issue_fsm u_issue_fsm (
        .clk       (clk),
        .rstn      (rstn),
        .i_ready   (i_ready),
        .i_hold    (hold),
        .i_stall   (stall),
        .o_request (o_request),
        .ctrl      (u_ctrl_if.fsm)
    );

endmodule

`default_nettype wire

/* verification/sched_checker.sv */
`default_nettype none

module sched_checker
    import sched_pkg::*;
(
    input logic   clk,
    input logic   rstn,
    input logic   i_ready,
    input logic   o_request,
    input instr_t o_iss0,
    input instr_t o_iss1
);

    // heads are only consumed from a ready queue
    request_needs_ready: assert property (
        @(posedge clk) disable iff (!rstn) !i_ready |-> !o_request
    ) else $error("request strobe while the queue was not ready");

    // slot 1 only ever holds the younger of a pair
    slot1_needs_slot0: assert property (
        @(posedge clk) disable iff (!rstn) o_iss1.valid |-> o_iss0.valid
    ) else $error("slot 1 valid while slot 0 empty");

    empty_after_reset: assert property (
        @(posedge clk) $rose(rstn) |-> !o_iss0.valid && !o_iss1.valid
    ) else $error("issue slot valid right after reset release");

endmodule

bind dual_issue_sched sched_checker u_sched_checker (
    .clk       (clk),
    .rstn      (rstn),
    .i_ready   (i_ready),
    .o_request (o_request),
    .o_iss0    (o_iss0),
    .o_iss1    (o_iss1)
);

`default_nettype wire

/* verification/tb_dual_issue_sched.sv */
`default_nettype none

module tb_dual_issue_sched
    import sched_pkg::*;
();

    localparam int     SEED           = 91;
    localparam int     TIMEOUT_CYCLES = 20;
    localparam instr_t EMPTY_SLOT     = '0;

    logic   clk;
    logic   rstn;
    logic   i_ready;
    instr_t i_dec0;
    instr_t i_dec1;
    logic   o_request;
    instr_t o_iss0;
    instr_t o_iss1;

    // decode queue model, heads at index 0 and 1
    instr_t          queue_q[$];
    logic            ready_en;
    logic            req_seen;
    logic [PC_W-1:0] pc_next;
    int              check_count;
    int              error_count;
    int              test_start;

    dual_issue_sched #(
        .STALL_ON_LOAD (1'b1)
    ) DUT (
        .clk       (clk),
        .rstn      (rstn),
        .i_ready   (i_ready),
        .i_dec0    (i_dec0),
        .i_dec1    (i_dec1),
        .o_request (o_request),
        .o_iss0    (o_iss0),
        .o_iss1    (o_iss1)
    );

    always #2 clk = ~clk;

    function automatic instr_t make_instr(unit_e unit, op_e op, logic use_imm,
                                          logic [REG_ADDR_W-1:0] rd,
                                          logic [REG_ADDR_W-1:0] rs1,
                                          logic [REG_ADDR_W-1:0] rs2);
        instr_t ins;
        ins         = '0;
        ins.valid   = 1'b1;
        ins.unit    = unit;
        ins.op      = op;
        ins.use_imm = use_imm;
        ins.rd      = rd;
        ins.rs1     = rs1;
        ins.rs2     = rs2;
        ins.pc      = pc_next;
        pc_next     = pc_next + 32'd4;
        return ins;
    endfunction

    function automatic logic [REG_ADDR_W-1:0] pick_reg(int lo, int hi);
        return REG_ADDR_W'($urandom_range(hi, lo));
    endfunction

    // an invalid slot carries don't-care payload
    task automatic check_instr(input instr_t got, input instr_t exp, input string what);
        logic ok;
        check_count++;
        ok = exp.valid ? (got === exp) : (got.valid === 1'b0);
        if (!ok) begin
            error_count++;
            $display("[FAIL] t=%0t %s: got valid %b pc %h, expected valid %b pc %h",
                     $time, what, got.valid, got.pc, exp.valid, exp.pc);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // present the heads after the edge, pop on a sampled request
    task automatic drive_cycle();
        @(posedge clk);
        #1;
        if (ready_en && queue_q.size() >= 2) begin
            i_ready = 1'b1;
            i_dec0  = queue_q[0];
            i_dec1  = queue_q[1];
        end else begin
            i_ready = 1'b0;
            i_dec0  = '0;
            i_dec1  = '0;
        end
        @(negedge clk);
        req_seen = o_request;
        if (o_request) begin
            void'(queue_q.pop_front());
            void'(queue_q.pop_front());
        end
    endtask

    task automatic wait_request(input string what);
        int n;
        n        = 0;
        req_seen = 1'b0;
        while (!req_seen && n < TIMEOUT_CYCLES) begin
            drive_cycle();
            n++;
        end
        if (!req_seen) begin
            error_count++;
            $display("timeout: no request from the scheduler within %0d cycles in %s",
                     TIMEOUT_CYCLES, what);
        end
    endtask

    // slots show the previous cycle's choice, request the current one
    task automatic step_expect(input instr_t exp0, input instr_t exp1, input logic exp_req,
                               input string what);
        drive_cycle();
        check_instr(o_iss0, exp0, {what, " slot 0"});
        check_instr(o_iss1, exp1, {what, " slot 1"});
        check_bit(req_seen, exp_req, {what, " request"});
    endtask

    task automatic settle();
        ready_en = 1'b0;
        queue_q.delete();
        repeat (3) drive_cycle();
    endtask

    task automatic push_ready(input instr_t a, input instr_t b);
        queue_q.push_back(a);
        queue_q.push_back(b);
        ready_en = 1'b1;
    endtask

    task automatic end_test(input string name);
        settle();
        $display("test %s done: %0d errors", name, error_count - test_start);
        test_start = error_count;
    endtask

    task automatic test_reset_idle();
        repeat (4) step_expect(EMPTY_SLOT, EMPTY_SLOT, 1'b0, "idle");
        end_test("reset_idle");
    endtask

    task automatic test_independent_pair();
        instr_t a;
        instr_t b;
        // low registers for the first, high ones for the second
        a = make_instr(U_ALU, OP_ADD, 1'b0, pick_reg(1, 15), pick_reg(1, 15), pick_reg(1, 15));
        b = make_instr(U_ALU, OP_XOR, 1'b0, pick_reg(16, 31), pick_reg(16, 31),
                       pick_reg(16, 31));
        push_ready(a, b);
        wait_request("independent pair");
        step_expect(a, b, 1'b0, "pair");
        end_test("independent_pair");
    endtask

    task automatic test_dependence_split();
        instr_t a;
        instr_t b;
        instr_t c;
        instr_t d;
        a = make_instr(U_ALU, OP_ADD, 1'b0, 5'd5, 5'd1, 5'd2);
        b = make_instr(U_ALU, OP_SUB, 1'b0, 5'd6, 5'd5, 5'd3);
        c = make_instr(U_ALU, OP_AND, 1'b0, 5'd7, 5'd8, 5'd9);
        d = make_instr(U_ALU, OP_OR, 1'b1, 5'd10, 5'd11, 5'd0);
        push_ready(a, b);
        queue_q.push_back(c);
        queue_q.push_back(d);
        wait_request("dependence split");
        step_expect(a, EMPTY_SLOT, 1'b1, "split first");
        step_expect(b, c, 1'b0, "buffer with head");
        step_expect(d, EMPTY_SLOT, 1'b0, "buffer alone");
        end_test("dependence_split");
    endtask

    task automatic expect_split(input instr_t x, input instr_t y, input string what);
        push_ready(x, y);
        wait_request(what);
        step_expect(x, EMPTY_SLOT, 1'b0, {what, " first"});
        step_expect(y, EMPTY_SLOT, 1'b0, {what, " second"});
        settle();
    endtask

    task automatic test_structural_split();
        instr_t s1;
        instr_t s2;
        instr_t b1;
        instr_t b2;
        s1 = make_instr(U_STORE, OP_SW, 1'b1, 5'd0, 5'd1, 5'd2);
        s2 = make_instr(U_STORE, OP_SW, 1'b1, 5'd0, 5'd3, 5'd4);
        expect_split(s1, s2, "two stores");
        b1 = make_instr(U_CTRL, OP_BEQ, 1'b0, 5'd0, 5'd5, 5'd6);
        b2 = make_instr(U_CTRL, OP_BNE, 1'b0, 5'd0, 5'd7, 5'd8);
        expect_split(b1, b2, "two branches");
        end_test("structural_split");
    endtask

    task automatic test_load_use();
        instr_t ld;
        instr_t x;
        instr_t u;
        instr_t v;
        ld = make_instr(U_LOAD, OP_LW, 1'b1, 5'd9, 5'd1, 5'd0);
        x  = make_instr(U_ALU, OP_ADD, 1'b0, 5'd4, 5'd2, 5'd3);
        u  = make_instr(U_ALU, OP_ADD, 1'b0, 5'd11, 5'd9, 5'd3);
        v  = make_instr(U_ALU, OP_SLT, 1'b0, 5'd12, 5'd13, 5'd14);
        push_ready(ld, x);
        queue_q.push_back(u);
        queue_q.push_back(v);
        wait_request("load use");
        step_expect(ld, x, 1'b0, "stall cycle");
        step_expect(EMPTY_SLOT, EMPTY_SLOT, 1'b1, "bubble");
        step_expect(u, v, 1'b0, "consumer");
        end_test("load_use");
    endtask

    task automatic test_drain();
        instr_t a;
        instr_t b;
        a = make_instr(U_ALU, OP_ADD, 1'b0, 5'd20, 5'd21, 5'd22);
        b = make_instr(U_ALU, OP_SRL, 1'b0, 5'd23, 5'd24, 5'd20);
        push_ready(a, b);
        queue_q.push_back(make_instr(U_ALU, OP_AND, 1'b0, 5'd25, 5'd26, 5'd27));
        queue_q.push_back(make_instr(U_ALU, OP_OR, 1'b0, 5'd28, 5'd29, 5'd30));
        wait_request("drain");
        // queue still holds two but stops offering them
        ready_en = 1'b0;
        step_expect(a, EMPTY_SLOT, 1'b0, "drain first");
        step_expect(b, EMPTY_SLOT, 1'b0, "drain buffer");
        step_expect(EMPTY_SLOT, EMPTY_SLOT, 1'b0, "drained");
        end_test("drain");
    endtask

    initial begin
        void'($urandom(SEED));
        clk         = 1'b0;
        rstn        = 1'b0;
        i_ready     = 1'b0;
        i_dec0      = '0;
        i_dec1      = '0;
        ready_en    = 1'b0;
        req_seen    = 1'b0;
        pc_next     = 32'h0000_0100;
        check_count = 0;
        error_count = 0;
        test_start  = 0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        test_reset_idle();
        test_independent_pair();
        test_dependence_split();
        test_structural_split();
        test_load_use();
        test_drain();

        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/sched_pkg.sv
verilog/issue_ctrl_if.sv
verilog/pair_hazard_check.sv
verilog/load_use_check.sv
verilog/issue_fsm.sv
verilog/issue_regs.sv
verilog/dual_issue_sched.sv
verification/sched_checker.sv
verification/tb_dual_issue_sched.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dual_issue_sched
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(BUILD_DIR)
